// ==== sim.f ====
design/bev_types_pkg.sv
design/bev_recipe_pkg.sv
design/bev_order_regs.sv
design/bev_ctrl.sv
design/bev_dram_port.sv
design/bev_box_update.sv
design/bev_top.sv
test/bev_props.sv
test/tb_bev.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_bev -f sim.f

out=$(./obj_dir/Vtb_bev || true)
printf '%s\n' "$out"

# Exit status follows the search for the pass line
printf '%s\n' "$out" | grep -q -F -x '*** PASSED ***'

// ==== test/tb_bev.sv ====
module tb_bev;
    import bev_types_pkg::*;

    localparam int n_cmds = 150;
    localparam int n_boxes = 16;
    localparam int max_cmd_cycles = 32;
    localparam int cycle_limit = n_cmds * max_cmd_cycles + 20;
    localparam time t_drv = 2;

    logic      clk;
    logic      inf;
    logic      sel_action_valid;
    logic      type_valid;
    logic      size_valid;
    logic      date_valid;
    logic      box_no_valid;
    logic      box_sup_valid;
    cmd_data_t cmd;
    logic      out_valid;
    err_msg_t  err_msg;
    logic      complete;
    dram_req_t dram_req;
    logic      c_out_valid;
    box_rec_t  c_data_r;

    box_rec_t  mem [n_boxes];
    box_rec_t  ref_mem [n_boxes];
    dram_req_t req_log [$];
    int        req_base = 0;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    bev_top #(.box_no_w(8)) UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    // Memory model, one request at a time, 1 to 4 cycles to answer
    initial
    begin
        int d;
        c_out_valid = 1'b0;
        c_data_r = '0;
        @(posedge inf);
        mem = ref_mem;
        forever
        begin
            @(posedge clk);
            if (dram_req.in_valid)
            begin
                req_log.push_back(dram_req);
                d = 1 + int'($urandom % 4);
                repeat (d - 1) @(posedge clk);
                #t_drv;
                if (dram_req.r_wb)
                    c_data_r = mem[dram_req.addr[3:0]];
                else
                    mem[dram_req.addr[3:0]] = dram_req.data_w;
                c_out_valid = 1'b1;
                @(posedge clk);
                #t_drv;
                c_out_valid = 1'b0;
            end
        end
    end

    task automatic check_err(input err_msg_t got, input err_msg_t exp, input string name);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got %s exp %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input logic [7:0] got, input logic [7:0] exp, input string name);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rec(input box_rec_t got, input box_rec_t exp, input string name);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    function automatic int quarters_of(input bev_type_t bt, input int ing);
        int q [4];
        case (bt)
            black_tea:           q = '{4, 0, 0, 0};
            milk_tea:            q = '{3, 0, 1, 0};
            extra_milk_tea:      q = '{2, 0, 2, 0};
            green_tea:           q = '{0, 4, 0, 0};
            green_milk_tea:      q = '{0, 2, 2, 0};
            pineapple_juice:     q = '{0, 0, 0, 4};
            super_pineapple_tea: q = '{2, 0, 0, 2};
            default:             q = '{2, 0, 1, 1};
        endcase
        return q[ing];
    endfunction

    // Reference model of one command on the model's copy of memory
    task automatic predict(input action_t act, input bev_type_t bt, input bev_size_t sz,
                           input date_t today, input int box, input int amt [4],
                           output err_msg_t exp_err, output logic exp_wr,
                           output box_rec_t exp_rec);
        box_rec_t r;
        int       have [4];
        int       vol;
        logic     expired;
        logic     short;
        logic     sat;
        r = ref_mem[box];
        have = '{int'(r.black_tea), int'(r.green_tea), int'(r.milk), int'(r.pineapple)};
        expired = r.exp_date.month < today.month ||
                  (r.exp_date.month == today.month && r.exp_date.day < today.day);
        vol = sz == s ? 480 : (sz == m ? 720 : 960);
        short = 1'b0;
        sat = 1'b0;
        exp_rec = r;
        exp_wr = 1'b0;
        exp_err = no_err;
        if (act == supply)
        begin
            for (int i = 0; i < 4; i++)
            begin
                have[i] += amt[i];
                if (have[i] > 4095)
                begin
                    have[i] = 4095;
                    sat = 1'b1;
                end
            end
            exp_wr = 1'b1;
            exp_err = sat ? ing_of : no_err;
            exp_rec.exp_date = today;
        end
        else if (expired)
            exp_err = no_exp;
        else if (act == make_drink)
        begin
            for (int i = 0; i < 4; i++)
            begin
                have[i] -= quarters_of(bt, i) * vol / 4;
                short |= have[i] < 0;
            end
            exp_wr = !short;
            exp_err = short ? no_ing : no_err;
        end
        if (exp_wr)
        begin
            exp_rec.black_tea = 12'(have[0]);
            exp_rec.green_tea = 12'(have[1]);
            exp_rec.milk = 12'(have[2]);
            exp_rec.pineapple = 12'(have[3]);
        end
    endtask

    task automatic strobe(input int field, input cmd_data_t value);
        cmd = value;
        case (field)
            0:       sel_action_valid = 1'b1;
            1:       type_valid = 1'b1;
            2:       size_valid = 1'b1;
            3:       date_valid = 1'b1;
            4:       box_no_valid = 1'b1;
            default: box_sup_valid = 1'b1;
        endcase
        @(posedge clk);
        #t_drv;
        {sel_action_valid, type_valid, size_valid} = '0;
        {date_valid, box_no_valid, box_sup_valid} = '0;
    endtask

    task automatic run_command();
        action_t   act;
        bev_type_t bt;
        bev_size_t sz;
        date_t     today;
        int        box;
        int        amt [4];
        int        n_req;
        err_msg_t  exp_err;
        logic      exp_wr;
        box_rec_t  exp_rec;
        cmd_data_t c;
        act = action_t'($urandom % 3);
        bt = bev_type_t'($urandom % 8);
        sz = bev_size_t'($urandom % 3);
        today.month = 4'(1 + $urandom % 12);
        today.day = 5'(1 + $urandom % 31);
        box = int'($urandom % n_boxes);
        for (int i = 0; i < 4; i++)
            amt[i] = ($urandom % 2 == 1) ? int'($urandom % 4096) : int'($urandom % 1024);
        // Unused fields of the bus carry junk
        c = {$urandom, $urandom};
        c.act = act;
        strobe(0, c);
        if (act == make_drink)
        begin
            c.bev_type = bt;
            strobe(1, c);
            c.bev_size = sz;
            strobe(2, c);
        end
        c.date = today;
        strobe(3, c);
        c.box_no = 8'(box);
        strobe(4, c);
        if (act == supply)
        begin
            for (int i = 0; i < 4; i++)
            begin
                c.ing = 12'(amt[i]);
                strobe(5, c);
            end
        end
        predict(act, bt, sz, today, box, amt, exp_err, exp_wr, exp_rec);
        do
            @(posedge clk);
        while (out_valid !== 1'b1);
        check_err(err_msg, exp_err, "err_msg");
        check_bit(complete, exp_err == no_err, "complete");
        n_req = req_log.size() - req_base;
        if (n_req != (exp_wr ? 2 : 1))
        begin
            errors++;
            $display("Error at %0t: %s command on box %0d expected %0d memory requests, saw %0d",
                     $time, act.name(), box, exp_wr ? 2 : 1, n_req);
        end
        else
        begin
            check_addr(req_log[req_base].addr, 8'(box), "dram_req.addr");
            check_bit(req_log[req_base].r_wb, 1'b1, "dram_req.r_wb");
            if (exp_wr)
            begin
                check_addr(req_log[req_base + 1].addr, 8'(box), "dram_req.addr");
                check_bit(req_log[req_base + 1].r_wb, 1'b0, "dram_req.r_wb");
                check_rec(req_log[req_base + 1].data_w, exp_rec, "dram_req.data_w");
            end
        end
        req_base = req_log.size();
        if (exp_wr)
            ref_mem[box] = exp_rec;
        #t_drv;
    endtask

    initial
    begin
        void'($urandom(32'hcfdf_d53e));
        inf = 1'b0;
        {sel_action_valid, type_valid, size_valid} = '0;
        {date_valid, box_no_valid, box_sup_valid} = '0;
        cmd = '0;
        for (int i = 0; i < n_boxes; i++)
        begin
            ref_mem[i].black_tea = 12'($urandom % 4096);
            ref_mem[i].green_tea = 12'($urandom % 4096);
            ref_mem[i].milk = 12'($urandom % 4096);
            ref_mem[i].pineapple = 12'($urandom % 4096);
            ref_mem[i].exp_date.month = 4'(1 + $urandom % 12);
            ref_mem[i].exp_date.day = 5'(1 + $urandom % 31);
        end
        repeat (5) @(posedge clk);
        #t_drv;
        inf = 1'b1;
        check_bit(out_valid, 1'b0, "out_valid");
        check_bit(complete, 1'b0, "complete");
        check_err(err_msg, no_err, "err_msg");
        check_bit(dram_req.in_valid, 1'b0, "dram_req.in_valid");
        for (int n = 0; n < n_cmds; n++)
            run_command();
        $display("Summary: %0d commands, %0d checks, %0d errors", n_cmds, checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== test/bev_props.sv ====
module bev_props
(
    input  logic                      clk,
    input  logic                      inf,
    input  logic                      out_valid,
    input  bev_types_pkg::err_msg_t   err_msg,
    input  logic                      complete,
    input  bev_types_pkg::dram_req_t  dram_req,
    input  logic                      c_out_valid
);
    import bev_types_pkg::*;

    logic req_open;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            req_open <= 1'b0;
        else if (dram_req.in_valid)
            req_open <= 1'b1;
        else if (c_out_valid)
            req_open <= 1'b0;
    end

    a_out_valid_pulse: assert property (@(posedge clk) disable iff (!inf)
        out_valid |=> !out_valid)
        else $error("out_valid held high for more than one cycle");

    a_in_valid_pulse: assert property (@(posedge clk) disable iff (!inf)
        dram_req.in_valid |=> !dram_req.in_valid)
        else $error("in_valid held high for more than one cycle");

    // One outstanding request at a time
    a_one_open_req: assert property (@(posedge clk) disable iff (!inf)
        dram_req.in_valid |-> !req_open)
        else $error("New memory request before the previous one was answered");

    a_complete_match: assert property (@(posedge clk) disable iff (!inf)
        out_valid |-> (complete == (err_msg == no_err)))
        else $error("complete disagrees with err_msg");

endmodule

bind bev_top bev_props u_props
(
    .clk, .inf, .out_valid, .err_msg, .complete, .dram_req, .c_out_valid
);

// ==== design/bev_top.sv ====
module bev_top
#(
    parameter int box_no_w = 8
)
(
    input  logic                      clk,
    input  logic                      inf,
    input  logic                      sel_action_valid,
    input  logic                      type_valid,
    input  logic                      size_valid,
    input  logic                      date_valid,
    input  logic                      box_no_valid,
    input  logic                      box_sup_valid,
    input  bev_types_pkg::cmd_data_t  cmd,
    output logic                      out_valid,
    output bev_types_pkg::err_msg_t   err_msg,
    output logic                      complete,
    output bev_types_pkg::dram_req_t  dram_req,
    input  logic                      c_out_valid,
    input  bev_types_pkg::box_rec_t   c_data_r
);
    import bev_types_pkg::*;

    phase_t               phase;
    box_cmd_t             box_cmd;
    logic [box_no_w-1:0]  box_no;
    supply_t              supply;
    logic                 sup_done;
    logic                 rd_start;
    logic                 wr_start;
    logic                 apply;
    logic                 rd_done;
    logic                 wr_done;
    box_rec_t             rd_data;
    box_rec_t             rec;
    err_msg_t             err;

    bev_order_regs #(.box_no_w(box_no_w)) u_order_regs (
        .clk, .inf, .phase,
        .sel_action_valid, .type_valid, .size_valid,
        .date_valid, .box_no_valid, .box_sup_valid,
        .cmd, .box_cmd, .box_no, .supply, .sup_done
    );

    bev_ctrl u_ctrl (
        .clk, .inf,
        .sel_action_valid, .type_valid, .size_valid,
        .date_valid, .box_no_valid, .cmd,
        .sup_done, .rd_done, .wr_done, .box_cmd, .err,
        .phase, .rd_start, .wr_start, .apply,
        .out_valid, .err_msg, .complete
    );

    bev_dram_port #(.box_no_w(box_no_w)) u_dram_port (
        .clk, .inf, .rd_start, .wr_start, .box_no,
        .wr_rec(rec), .dram_req, .c_out_valid, .c_data_r,
        .rd_done, .wr_done, .rd_data
    );

    bev_box_update u_box_update (
        .clk, .inf, .rd_done, .rd_data, .apply,
        .box_cmd, .supply, .rec, .err
    );

endmodule

// ==== design/bev_box_update.sv ====
module bev_box_update
(
    input  logic                     clk,
    input  logic                     inf,
    input  logic                     rd_done,
    input  bev_types_pkg::box_rec_t  rd_data,
    input  logic                     apply,
    input  bev_types_pkg::box_cmd_t  box_cmd,
    input  bev_types_pkg::supply_t   supply,
    output bev_types_pkg::box_rec_t  rec,
    output bev_types_pkg::err_msg_t  err
);
    import bev_types_pkg::*;
    import bev_recipe_pkg::*;

    recipe_t          quarters;
    ing_amt_t         quarter_vol;
    ing_amt_t [0:3]   stock;
    ing_amt_t [0:3]   need;
    ing_amt_t [0:3]   used;
    ing_amt_t [0:3]   filled;
    logic [12:0]      diff [4];
    logic [12:0]      sum [4];
    logic             lacking;
    logic             overflow;
    logic             expired;
    box_rec_t         next_rec;
    err_msg_t         next_err;

    assign stock    = {rec.black_tea, rec.green_tea, rec.milk, rec.pineapple};
    assign quarters = recipe_quarters[box_cmd.bev_type];
    assign expired  = {rec.exp_date.month, rec.exp_date.day} <
                      {box_cmd.date.month, box_cmd.date.day};

    always_comb
    begin
        case (box_cmd.bev_size)
            s:       quarter_vol = cup_vol_s >> 2;
            m:       quarter_vol = cup_vol_m >> 2;
            default: quarter_vol = cup_vol_l >> 2;
        endcase
    end

    // Borrow out of bit 12 means the ingredient runs short
    always_comb
    begin
        lacking  = 1'b0;
        overflow = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            need[i] = 12'(quarters[i]) * quarter_vol;
            diff[i] = {1'b0, stock[i]} - {1'b0, need[i]};
            used[i] = diff[i][11:0];
            lacking = lacking | diff[i][12];
            sum[i]  = {1'b0, stock[i]} + {1'b0, supply[i]};
            if (sum[i] > {1'b0, ing_full_scale})
            begin
                filled[i] = ing_full_scale;
                overflow  = 1'b1;
            end
            else
            begin
                filled[i] = sum[i][11:0];
            end
        end
    end

    always_comb
    begin
        next_rec = rec;
        next_err = no_err;
        case (box_cmd.act)
            make_drink:
            begin
                if (expired)
                    next_err = no_exp;
                else if (lacking)
                    next_err = no_ing;
                else
                    {next_rec.black_tea, next_rec.green_tea, next_rec.milk,
                     next_rec.pineapple} = used;
            end
            check_date:
            begin
                if (expired)
                    next_err = no_exp;
            end
            default:
            begin
                // Supply refreshes the expiry date too
                {next_rec.black_tea, next_rec.green_tea, next_rec.milk,
                 next_rec.pineapple} = filled;
                next_rec.exp_date = box_cmd.date;
                if (overflow)
                    next_err = ing_of;
            end
        endcase
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            err <= no_err;
        else if (apply)
            err <= next_err;
    end

    always_ff @(posedge clk)
    begin
        if (rd_done)
            rec <= rd_data;
        else if (apply)
            rec <= next_rec;
    end

endmodule

// ==== design/bev_dram_port.sv ====
module bev_dram_port
#(
    parameter int box_no_w = 8
)
(
    input  logic                      clk,
    input  logic                      inf,
    input  logic                      rd_start,
    input  logic                      wr_start,
    input  logic [box_no_w-1:0]       box_no,
    input  bev_types_pkg::box_rec_t   wr_rec,
    output bev_types_pkg::dram_req_t  dram_req,
    input  logic                      c_out_valid,
    input  bev_types_pkg::box_rec_t   c_data_r,
    output logic                      rd_done,
    output logic                      wr_done,
    output bev_types_pkg::box_rec_t   rd_data
);
    import bev_types_pkg::*;

    logic [7:0] addr;
    logic       r_wb;
    logic       in_valid;
    logic       busy;
    box_rec_t   data_w;

    assign dram_req = '{addr: addr, r_wb: r_wb, in_valid: in_valid, data_w: data_w};

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            addr     <= '0;
            r_wb     <= 1'b0;
            in_valid <= 1'b0;
            busy     <= 1'b0;
        end
        else
        begin
            in_valid <= 1'b0;
            if (rd_start || wr_start)
            begin
                addr     <= 8'(box_no);
                r_wb     <= rd_start;
                in_valid <= 1'b1;
                busy     <= 1'b1;
            end
            else if (busy && c_out_valid)
            begin
                addr <= '0;
                r_wb <= 1'b0;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_start)
            data_w <= wr_rec;
    end

    // Response kind follows the pending request
    assign rd_done = busy && c_out_valid && r_wb;
    assign wr_done = busy && c_out_valid && !r_wb;
    assign rd_data = c_data_r;

endmodule

// ==== design/bev_ctrl.sv ====
module bev_ctrl
(
    input  logic                      clk,
    input  logic                      inf,
    input  logic                      sel_action_valid,
    input  logic                      type_valid,
    input  logic                      size_valid,
    input  logic                      date_valid,
    input  logic                      box_no_valid,
    input  bev_types_pkg::cmd_data_t  cmd,
    input  logic                      sup_done,
    input  logic                      rd_done,
    input  logic                      wr_done,
    input  bev_types_pkg::box_cmd_t   box_cmd,
    input  bev_types_pkg::err_msg_t   err,
    output bev_types_pkg::phase_t     phase,
    output logic                      rd_start,
    output logic                      wr_start,
    output logic                      apply,
    output logic                      out_valid,
    output bev_types_pkg::err_msg_t   err_msg,
    output logic                      complete
);
    import bev_types_pkg::*;

    phase_t state;
    phase_t next_state;
    logic   need_wr;
    logic   report;

    // Supply always writes back, a drink only when it succeeded
    assign need_wr = box_cmd.act == supply || (box_cmd.act == make_drink && err == no_err);
    assign report  = (state == ph_decide && !need_wr) || state == ph_report;
    assign phase   = state;
    assign apply   = state == ph_apply;

    always_comb
    begin
        next_state = state;
        case (state)
            ph_idle:
            begin
                if (sel_action_valid && cmd.act == make_drink)
                    next_state = ph_type;
                else if (sel_action_valid && (cmd.act == supply || cmd.act == check_date))
                    next_state = ph_date;
            end
            ph_type:
                if (type_valid)
                    next_state = ph_size;
            ph_size:
                if (size_valid)
                    next_state = ph_date;
            ph_date:
                if (date_valid)
                    next_state = ph_box;
            ph_box:
                if (box_no_valid)
                    next_state = box_cmd.act == supply ? ph_sup : ph_read;
            ph_sup:
                if (sup_done)
                    next_state = ph_read;
            ph_read:
                if (rd_done)
                    next_state = ph_apply;
            ph_apply:
                next_state = ph_decide;
            ph_decide:
                next_state = need_wr ? ph_write : ph_idle;
            ph_write:
                if (wr_done)
                    next_state = ph_report;
            default:
                next_state = ph_idle;
        endcase
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            state     <= ph_idle;
            rd_start  <= 1'b0;
            wr_start  <= 1'b0;
            out_valid <= 1'b0;
            err_msg   <= no_err;
            complete  <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            // Start pulses land in the first cycle of read and write
            rd_start  <= next_state == ph_read && state != ph_read;
            wr_start  <= next_state == ph_write && state != ph_write;
            out_valid <= report;
            err_msg   <= report ? err : no_err;
            complete  <= report && err == no_err;
        end
    end

endmodule

// ==== design/bev_order_regs.sv ====
module bev_order_regs
#(
    parameter int box_no_w = 8
)
(
    input  logic                       clk,
    input  logic                       inf,
    input  bev_types_pkg::phase_t      phase,
    input  logic                       sel_action_valid,
    input  logic                       type_valid,
    input  logic                       size_valid,
    input  logic                       date_valid,
    input  logic                       box_no_valid,
    input  logic                       box_sup_valid,
    input  bev_types_pkg::cmd_data_t   cmd,
    output bev_types_pkg::box_cmd_t    box_cmd,
    output logic [box_no_w-1:0]        box_no,
    output bev_types_pkg::supply_t     supply,
    output logic                       sup_done
);
    import bev_types_pkg::*;

    logic [1:0] sup_cnt;
    logic       sup_take;

    assign sup_take = phase == ph_sup && box_sup_valid;
    assign sup_done = sup_take && sup_cnt == 2'd3;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            box_cmd <= '0;
            box_no  <= '0;
            sup_cnt <= '0;
        end
        else
        begin
            case (phase)
                ph_idle:
                begin
                    sup_cnt <= '0;
                    if (sel_action_valid)
                        box_cmd.act <= cmd.act;
                end
                ph_type:
                    if (type_valid)
                        box_cmd.bev_type <= cmd.bev_type;
                ph_size:
                    if (size_valid)
                        box_cmd.bev_size <= cmd.bev_size;
                ph_date:
                    if (date_valid)
                        box_cmd.date <= cmd.date;
                ph_box:
                    if (box_no_valid)
                        box_no <= box_no_w'(cmd.box_no);
                ph_sup:
                    if (box_sup_valid)
                        sup_cnt <= sup_cnt + 2'd1;
                default:
                    ;
            endcase
        end
    end

    // Amounts arrive in ingredient order
    always_ff @(posedge clk)
    begin
        if (sup_take)
            supply[sup_cnt] <= cmd.ing;
    end

endmodule

// ==== design/bev_recipe_pkg.sv ====
package bev_recipe_pkg;

    localparam logic [11:0] cup_vol_s = 12'd480;
    localparam logic [11:0] cup_vol_m = 12'd720;
    localparam logic [11:0] cup_vol_l = 12'd960;

    localparam logic [11:0] ing_full_scale = 12'd4095;

    // Quarters of the cup from black tea, green tea, milk and pineapple
    typedef logic [0:3][2:0] recipe_t;

    localparam recipe_t recipe_quarters [8] = '{
        '{3'd4, 3'd0, 3'd0, 3'd0},  // black tea
        '{3'd3, 3'd0, 3'd1, 3'd0},  // milk tea
        '{3'd2, 3'd0, 3'd2, 3'd0},  // extra milk tea
        '{3'd0, 3'd4, 3'd0, 3'd0},  // green tea
        '{3'd0, 3'd2, 3'd2, 3'd0},  // green milk tea
        '{3'd0, 3'd0, 3'd0, 3'd4},  // pineapple juice
        '{3'd2, 3'd0, 3'd0, 3'd2},  // super pineapple tea
        '{3'd2, 3'd0, 3'd1, 3'd1}   // super pineapple milk tea
    };

endpackage

// ==== design/bev_types_pkg.sv ====
package bev_types_pkg;

    typedef enum logic [1:0] {make_drink, supply, check_date} action_t;

    typedef enum logic [2:0]
    {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_t;

    typedef enum logic [1:0] {s, m, l} bev_size_t;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    typedef logic [11:0] ing_amt_t;

    typedef struct packed {
        ing_amt_t black_tea;
        ing_amt_t green_tea;
        ing_amt_t milk;
        ing_amt_t pineapple;
        date_t    exp_date;
    } box_rec_t;

    typedef enum logic [1:0] {no_err, no_exp, no_ing, ing_of} err_msg_t;

    // Shared command bus, the strobe tells which field is valid
    typedef struct packed {
        logic [27:0] rsvd;
        action_t     act;
        bev_type_t   bev_type;
        bev_size_t   bev_size;
        date_t       date;
        logic [7:0]  box_no;
        ing_amt_t    ing;
    } cmd_data_t;

    typedef struct packed {
        logic [7:0] addr;
        logic       r_wb;
        logic       in_valid;
        box_rec_t   data_w;
    } dram_req_t;

    typedef struct packed {
        action_t   act;
        bev_type_t bev_type;
        bev_size_t bev_size;
        date_t     date;
    } box_cmd_t;

    // Black tea, green tea, milk, pineapple
    typedef ing_amt_t [0:3] supply_t;

    typedef enum logic [3:0]
    {
        ph_idle,
        ph_type,
        ph_size,
        ph_date,
        ph_box,
        ph_sup,
        ph_read,
        ph_apply,
        ph_decide,
        ph_write,
        ph_report
    } phase_t;

endpackage
